//--- bp_btb.sv
//------------------------------
// Direct-mapped BTB with update port
//------------------------------
`timescale 1ns/1ps

module bp_btb (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic [bp_pkg::ADDR_BITS-1:0]    i_lookup_pc,  // Response address
    input  bp_pkg::bp_btb_upd_t             i_upd,        // Write from execute
    output logic                            o_hit,
    output logic [bp_pkg::ADDR_BITS-1:0]    o_target
);

    import bp_pkg::*;

    logic [BTB_ENTRIES-1:0]           valid_q;
    logic [ADDR_BITS-1:BTB_IDX_BITS+2] tag_q [BTB_ENTRIES];    // pc[31:5]
    logic [ADDR_BITS-1:0]             target_q [BTB_ENTRIES];
    logic [BTB_IDX_BITS-1:0]          rd_idx;
    logic [BTB_IDX_BITS-1:0]          wr_idx;

    assign rd_idx = i_lookup_pc[BTB_IDX_BITS+1:2];        // Word index
    assign wr_idx = i_upd.pc[BTB_IDX_BITS+1:2];

    // Valid bits
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
        end else if (i_upd.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge i_clk) begin
        if (i_upd.valid) begin
            tag_q[wr_idx]    <= i_upd.pc[ADDR_BITS-1:BTB_IDX_BITS+2];
            target_q[wr_idx] <= i_upd.target;             // Overwrites old entry
        end
    end

    // Lookup path is combinational, writes seen next cycle
    assign o_hit = valid_q[rd_idx]
                && (tag_q[rd_idx] == i_lookup_pc[ADDR_BITS-1:BTB_IDX_BITS+2]);
    assign o_target = target_q[rd_idx];

endmodule

//--- bp_fetch_ctrl.sv
//------------------------------
// Fetch FSM and next-PC priority select
//------------------------------
`timescale 1ns/1ps

module bp_fetch_ctrl (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_stall,      // Level, holds fetch
    input  logic                            i_resp_valid,
    input  bp_pkg::bp_predec_t              i_predec,
    input  logic                            i_btb_hit,
    input  logic [bp_pkg::ADDR_BITS-1:0]    i_btb_target,
    input  bp_pkg::bp_redirect_t            i_redirect,   // From execute
    output bp_pkg::bp_req_t                 o_req,
    output logic                            o_jmp         // Pre-decoded jump pulse
);

    import bp_pkg::*;

    bp_state_e            state_q;
    bp_state_e            state_d;
    logic [ADDR_BITS-1:0] pc_q;
    logic [ADDR_BITS-1:0] pc_d;
    logic                 resp_go;                         // Response taken this cycle

    // Responses dropped while stall is up
    assign resp_go = i_resp_valid && !i_stall;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RESET: state_d = i_stall ? ST_STALL : ST_RUN;  // Single idle cycle
            ST_RUN:   state_d = i_stall ? ST_STALL : ST_RUN;
            ST_STALL: state_d = i_stall ? ST_STALL : ST_RUN;
            default:  state_d = ST_RESET;
        endcase
    end

    // Redirect, then pre-decode, then BTB, then pc + 4
    always_comb begin
        pc_d = pc_q;                                       // Hold when idle
        if (i_redirect.valid) begin
            pc_d = i_redirect.pc;
        end else if (resp_go) begin
            if (i_predec.kind != JMP_NONE) begin
                pc_d = i_predec.npc;
            end else if (i_btb_hit) begin
                pc_d = i_btb_target;
            end else begin
                pc_d = i_predec.npc;                       // Sequential
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_RESET;
            pc_q    <= RESET_VECTOR;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign o_req = '{valid: (state_q == ST_RUN), pc: pc_q};
    assign o_jmp = resp_go && (i_predec.kind != JMP_NONE);

endmodule

//--- bp_golden.txt
# rv cv addr data ra | redir_v redir_pc | upd_v upd_pc upd_tgt | stall
# exp_jmp exp_req_valid exp_req_pc (all hex)
# Idle after reset
0 0 00000000 00000000 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00001000
# Sequential fetch
1 0 00001000 00000013 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00001004
# JAL +0x100
1 0 00001004 1000006f 0000000000000000 0 00000000 0 00000000 00000000 0 1 1 00001104
# Backward branch -8, then forward branch +8
1 0 00001104 fe000ce3 0000000000000000 0 00000000 0 00000000 00000000 0 1 1 000010fc
1 0 000010fc 00000463 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00001100
# C.J +0x20 with and without c_valid
1 1 00001100 0000a005 0000000000000000 0 00000000 0 00000000 00000000 0 1 1 00001120
1 0 00001120 0000a005 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00001124
# C.RET takes the low half of ra
1 1 00001124 00008082 ffff000000002000 0 00000000 0 00000000 00000000 0 1 1 00002000
# BTB fill, hit, then same index with other tag
0 0 00000000 00000000 0000000000000000 0 00000000 1 00002000 00003000 0 0 1 00002000
1 0 00002000 00000013 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00003000
1 0 00003000 00000013 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00003004
# Redirect beats JAL
1 0 00003004 1000006f 0000000000000000 1 00004000 0 00000000 00000000 0 1 1 00004000
# Stall, response ignored, redirect still moves pc
0 0 00000000 00000000 0000000000000000 0 00000000 0 00000000 00000000 1 0 0 00004000
1 0 00004000 1000006f 0000000000000000 0 00000000 0 00000000 00000000 1 0 0 00004000
0 0 00000000 00000000 0000000000000000 1 00005000 0 00000000 00000000 1 0 0 00005000
0 0 00000000 00000000 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00005000
# Backward JAL -4
1 0 00005000 00000013 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00005004
1 0 00005004 ffdff06f 0000000000000000 0 00000000 0 00000000 00000000 0 1 1 00005000
# Update and lookup in one cycle misses, hits next cycle
1 0 00005000 00000013 0000000000000000 0 00000000 1 00005000 00006000 0 0 1 00005004
1 0 00005000 00000013 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00006000
# Pre-decoded JAL beats BTB hit
1 0 00005000 1000006f 0000000000000000 0 00000000 0 00000000 00000000 0 1 1 00005100
0 0 00000000 00000000 0000000000000000 0 00000000 0 00000000 00000000 0 0 1 00005100

//--- bp_pkg.sv
//------------------------------
// Shared widths, reset vector and BTB size
// Fetch FSM and jump kind enums, bus structs
//------------------------------
package bp_pkg;

    localparam int ADDR_BITS = 32;                    // Fetch address width
    localparam int XLEN = 64;                         // Register width
    localparam logic [ADDR_BITS-1:0] RESET_VECTOR = 32'h0000_1000;
    localparam int BTB_ENTRIES = 8;
    localparam int BTB_IDX_BITS = 3;                  // Index from pc[4:2]

    typedef enum logic [1:0] {
        ST_RESET,                                     // One idle cycle after reset
        ST_RUN,
        ST_STALL
    } bp_state_e;

    typedef enum logic [2:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_BRANCH,                                   // Backward branches only
        JMP_CJ,
        JMP_CRET
    } bp_jmp_e;

    // Memory response
    typedef struct packed {
        logic                 valid;
        logic                 c_valid;                // Compressed decode allowed
        logic [ADDR_BITS-1:0] addr;
        logic [31:0]          data;
    } bp_resp_t;

    typedef struct packed {
        bp_jmp_e              kind;
        logic [ADDR_BITS-1:0] npc;                    // Target or addr + 4
    } bp_predec_t;

    // Execute stage writes
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
        logic [ADDR_BITS-1:0] target;
    } bp_btb_upd_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
    } bp_redirect_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
    } bp_req_t;

endpackage

//--- bp_predecoder.sv
//------------------------------
// Jump pre-decoder for fetched words
// JAL, backward branch, C.J, C.RET targets
//------------------------------
`timescale 1ns/1ps

module bp_predecoder (
    input  bp_pkg::bp_resp_t          i_resp,     // Fetch response word
    input  logic [bp_pkg::XLEN-1:0]   i_ra,       // Return address register
    output bp_pkg::bp_predec_t        o_predec    // Jump kind and next pc
);

    import bp_pkg::*;

    logic [31:0]          inst;
    logic [ADDR_BITS-1:0] jal_imm;
    logic [ADDR_BITS-1:0] br_imm;
    logic [ADDR_BITS-1:0] cj_imm;
    logic [ADDR_BITS-1:0] jal_tgt;
    logic [ADDR_BITS-1:0] br_tgt;
    logic [ADDR_BITS-1:0] cj_tgt;
    logic                 is_jal;
    logic                 is_branch;
    logic                 is_cj;
    logic                 is_cret;

    assign inst = i_resp.data;

    // J-type offset, sign from bit 31
    assign jal_imm = {{(ADDR_BITS-20){inst[31]}}, inst[19:12], inst[20],
                      inst[30:21], 1'b0};
    // B-type offset
    assign br_imm = {{(ADDR_BITS-12){inst[31]}}, inst[7], inst[30:25],
                     inst[11:8], 1'b0};
    // CJ offset, scrambled field of the 16-bit word
    assign cj_imm = {{(ADDR_BITS-11){inst[12]}}, inst[8], inst[10:9], inst[6],
                     inst[7], inst[2], inst[11], inst[5:3], 1'b0};

    assign jal_tgt = i_resp.addr + jal_imm;
    assign br_tgt  = i_resp.addr + br_imm;
    assign cj_tgt  = i_resp.addr + cj_imm;

    assign is_jal    = (inst[6:0] == 7'h6f);
    assign is_branch = (inst[6:0] == 7'h63) && inst[31];   // Negative offset only
    assign is_cj     = i_resp.c_valid && (inst[15:13] == 3'h5) && (inst[1:0] == 2'h1);
    assign is_cret   = i_resp.c_valid && (inst[15:0] == 16'h8082);

    always_comb begin
        bp_jmp_e kind;

        kind = JMP_NONE;
        o_predec.npc = i_resp.addr + 32'd4;                // Fall-through default
        if (is_jal) begin
            kind = JMP_JAL;
            o_predec.npc = jal_tgt;
        end else if (is_branch) begin
            kind = JMP_BRANCH;
            o_predec.npc = br_tgt;
        end else if (is_cj) begin
            kind = JMP_CJ;
            o_predec.npc = cj_tgt;
        end else if (is_cret) begin
            kind = JMP_CRET;
            o_predec.npc = i_ra[ADDR_BITS-1:0];            // RAS stand-in
        end
        // No jump without a live response
        o_predec.kind = i_resp.valid ? kind : JMP_NONE;
    end

endmodule

//--- bp_sva.sv
//------------------------------
// Bound checks on bp_top ports
//------------------------------
`timescale 1ns/1ps

module bp_sva (
    input logic              i_clk,
    input logic              i_arst_n,
    input bp_pkg::bp_resp_t  i_resp,
    input bp_pkg::bp_req_t   o_req,
    input logic              o_jmp
);

    // First cycle out of reset is idle
    a_idle_after_rst: assert property (@(posedge i_clk) $rose(i_arst_n) |-> !o_req.valid)
        else $error("o_req.valid high in first cycle after reset");

    a_pc_even: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_req.pc[0] == 1'b0)
        else $error("o_req.pc is odd");

    // Jump pulse needs a live response
    a_jmp_resp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_jmp |-> i_resp.valid)
        else $error("o_jmp without a valid response");

endmodule

bind bp_top bp_sva u_sva (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_resp   (i_resp),
    .o_req    (o_req),
    .o_jmp    (o_jmp)
);

//--- bp_top.sv
//------------------------------
// Prediction front end top level
//------------------------------
`timescale 1ns/1ps

module bp_top (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  bp_pkg::bp_resp_t            i_resp,       // Memory response
    input  logic [bp_pkg::XLEN-1:0]     i_ra,
    input  bp_pkg::bp_redirect_t        i_redirect,
    input  bp_pkg::bp_btb_upd_t         i_btb_upd,
    input  logic                        i_stall,
    output bp_pkg::bp_req_t             o_req,        // Next fetch
    output logic                        o_jmp
);

    import bp_pkg::*;

    bp_predec_t           predec;
    logic                 btb_hit;
    logic [ADDR_BITS-1:0] btb_target;

    bp_predecoder u_predec (
        .i_resp   (i_resp),
        .i_ra     (i_ra),
        .o_predec (predec)
    );

    // Looked up with the response address
    bp_btb u_btb (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_lookup_pc (i_resp.addr),
        .i_upd       (i_btb_upd),
        .o_hit       (btb_hit),
        .o_target    (btb_target)
    );

    bp_fetch_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_stall      (i_stall),
        .i_resp_valid (i_resp.valid),
        .i_predec     (predec),
        .i_btb_hit    (btb_hit),
        .i_btb_target (btb_target),
        .i_redirect   (i_redirect),
        .o_req        (o_req),
        .o_jmp        (o_jmp)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch prediction testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_bp -f tb.f || exit 1
out=$(./obj_dir/Vtb_bp)
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1

//--- tb.f
bp_pkg.sv
bp_predecoder.sv
bp_btb.sv
bp_fetch_ctrl.sv
bp_top.sv
bp_sva.sv
tb_bp.sv

//--- tb_bp.sv
//------------------------------
// Golden-vector testbench for bp_top
// Reset check, vector replay, timeouts
//------------------------------
`timescale 1ns/1ps

module tb_bp;

    import bp_pkg::*;

    localparam int CLK_HALF    = 5;                    // 10 ns period
    localparam int RST_CYCLES  = 4;
    localparam int RST_TIMEOUT = 20;                   // Cycles allowed for reset release
    localparam int VEC_TIMEOUT = 500;                  // Cycle budget for the replay

    logic            clk;
    logic            arst_n;
    bp_resp_t        resp;
    logic [XLEN-1:0] ra;
    bp_redirect_t    redirect;
    bp_btb_upd_t     btb_upd;
    logic            stall;
    bp_req_t         req;
    logic            jmp;

    // Fields of one golden line
    logic                 v_rv;
    logic                 v_cv;
    logic [ADDR_BITS-1:0] v_addr;
    logic [31:0]          v_data;
    logic [XLEN-1:0]      v_ra;
    logic                 v_rdv;
    logic [ADDR_BITS-1:0] v_rdpc;
    logic                 v_uv;
    logic [ADDR_BITS-1:0] v_upc;
    logic [ADDR_BITS-1:0] v_utgt;
    logic                 v_stall;
    logic                 e_jmp;                       // Same-cycle expectation
    logic                 e_valid;                     // Next-cycle expectations
    logic [ADDR_BITS-1:0] e_pc;

    bp_top UUT (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_resp     (resp),
        .i_ra       (ra),
        .i_redirect (redirect),
        .i_btb_upd  (btb_upd),
        .i_stall    (stall),
        .o_req      (req),
        .o_jmp      (jmp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Reset held low for four rising edges
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    // Put the current golden line on the DUT inputs
    task drive_vector();
        resp     = '{valid: v_rv, c_valid: v_cv, addr: v_addr, data: v_data};
        ra       = v_ra;
        redirect = '{valid: v_rdv, pc: v_rdpc};
        btb_upd  = '{valid: v_uv, pc: v_upc, target: v_utgt};
        stall    = v_stall;
    endtask

    initial begin
        int    fd;
        int    nf;
        int    nvec;
        int    cnt;
        string line;

        resp     = '0;
        ra       = '0;
        redirect = '0;
        btb_upd  = '0;
        stall    = 1'b0;
        nvec     = 0;

        fd = $fopen("bp_golden.txt", "r");
        if (fd == 0) abort_run("could not open bp_golden.txt for reading");

        cnt = 0;
        while (arst_n !== 1'b1) begin                  // Reset release
            @(negedge clk);
            cnt++;
            if (cnt > RST_TIMEOUT) abort_run("reset was never released");
        end
        // Idle cycle at the reset vector
        check_val("o_req.valid", 32'(req.valid), 32'd0);
        check_val("o_req.pc", req.pc, RESET_VECTOR);
        @(posedge clk);
        #1;
        check_val("o_req.valid", 32'(req.valid), 32'd1);   // Run after one idle cycle
        check_val("o_req.pc", req.pc, RESET_VECTOR);

        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if (line.len() < 2 || line.getc(0) == 8'h23) continue;   // Blank or comment
            nf = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         v_rv, v_cv, v_addr, v_data, v_ra, v_rdv, v_rdpc,
                         v_uv, v_upc, v_utgt, v_stall, e_jmp, e_valid, e_pc);
            if (nf != 14) abort_run("bp_golden.txt holds a line with missing fields");
            nvec++;
            if (nvec > VEC_TIMEOUT) abort_run("vector replay ran past its cycle limit");
            drive_vector();
            @(negedge clk);
            check_val("o_jmp", 32'(jmp), 32'(e_jmp));  // Combinational pulse
            @(posedge clk);
            #1;
            check_val("o_req.valid", 32'(req.valid), 32'(e_valid));
            check_val("o_req.pc", req.pc, e_pc);
        end
        $fclose(fd);

        if (nvec == 0) begin
            abort_run("bp_golden.txt held no vectors");
        end else begin
            $display("Applied %0d vectors", nvec);
            $display("Regression passed");
            $finish;
        end
    end

endmodule
